// ==== include/opp_settings.svh ====
`ifndef OPP_SETTINGS_SVH
`define OPP_SETTINGS_SVH

//////////////////////////////
// widths and compute latency
//////////////////////////////

`define OPP_W_IN          18  // error sample width
`define OPP_W_OUT         16  // output word, bounds and init width

// one cycle per datapath stage
`define OPP_COMP_LATENCY  3   // mult, acc, clamp

`endif

// ==== src/opp_pkg.sv ====
package opp_pkg;

	//////////////////////////////
	// control FSM states
	//////////////////////////////

	typedef enum logic [1:0] {
		st_idle    = 2'd0,  // wait for a valid sample
		st_compute = 2'd1,  // step through datapath stages
		st_send    = 2'd2,  // four-phase transfer to dac queue
		st_done    = 2'd3   // commit result as previous output
	} opp_state_t;

	//////////////////////////////
	// datapath stage opcodes
	//////////////////////////////

	// issued by the control, one per compute cycle
	typedef enum logic [1:0] {
		stg_none  = 2'd0,  // hold all stage registers
		stg_mult  = 2'd1,  // register sample times gain
		stg_acc   = 2'd2,  // add previous output
		stg_clamp = 2'd3   // window limit or init select
	} opp_stage_t;

endpackage

// ==== src/opp_param_bank.sv ====
`timescale 1ns/1ns
`include "opp_settings.svh"

module opp_param_bank (
	input  logic                         clk_in,          // system clock
	input  logic                         reset_in,        // async reset
	input  logic                         update,          // panel update pulse
	input  logic                         update_en,       // arms the update pulse

	// values from the front panel
	input  logic signed [`OPP_W_OUT-1:0] out_max_in_val,  // upper bound
	input  logic signed [`OPP_W_OUT-1:0] out_min_in_val,  // lower bound
	input  logic signed [`OPP_W_OUT-1:0] out_init_in_val, // initial output
	input  logic signed [7:0]            gain_in_val,     // signed gain

	// active settings to the datapath
	output logic signed [`OPP_W_OUT-1:0] act_max,         // active upper bound
	output logic signed [`OPP_W_OUT-1:0] act_min,         // active lower bound
	output logic signed [`OPP_W_OUT-1:0] act_init,        // active initial value
	output logic signed [7:0]            act_gain,        // active gain
	output logic                         reload           // restart accumulator
);

	//////////////////////////////
	// update qualification
	//////////////////////////////

	logic load;  // gated update, the only place update_en is tested

	assign load = update & update_en;

	//////////////////////////////
	// active parameter registers
	//////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			act_max  <= '0;  // all settings clear on reset
			act_min  <= '0;
			act_init <= '0;
			act_gain <= '0;
		end else if (load) begin
			act_max  <= out_max_in_val;
			act_min  <= out_min_in_val;
			act_init <= out_init_in_val;
			act_gain <= gain_in_val;
		end
	end

	//////////////////////////////
	// reload strobe
	//////////////////////////////

	// The strobe follows the latching edge by one cycle, so act_init
	// already carries the new initial value when the datapath reloads.
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			reload <= 1'b0;
		end else begin
			reload <= load;  // single-cycle pulse
		end
	end

endmodule

// ==== src/opp_datapath.sv ====
`timescale 1ns/1ns
`include "opp_settings.svh"

module opp_datapath (
	input  logic                         clk_in,    // system clock
	input  logic                         reset_in,  // async reset
	input  logic signed [`OPP_W_IN-1:0]  sample,    // raw error sample
	input  logic                         capture,   // latch sample
	input  opp_pkg::opp_stage_t          stage,     // stage to advance
	input  logic                         commit,    // result becomes previous output
	input  logic                         reload,    // previous output from init
	input  logic signed [`OPP_W_OUT-1:0] act_max,   // upper bound
	input  logic signed [`OPP_W_OUT-1:0] act_min,   // lower bound
	input  logic signed [`OPP_W_OUT-1:0] act_init,  // initial value
	input  logic signed [7:0]            act_gain,  // signed gain
	input  logic                         lock_en,   // lock closed when high
	output logic signed [`OPP_W_OUT-1:0] result     // clamped output word
);
	import opp_pkg::*;

	localparam int W_IN  = `OPP_W_IN;
	localparam int W_OUT = `OPP_W_OUT;
	localparam int P_W   = W_OUT + 9;  // product and sum width

	logic signed [W_OUT-1:0] sample_cnv;  // sample at output width
	logic signed [W_OUT-1:0] sample_q;    // captured sample
	logic signed [W_OUT-1:0] prev_out;    // previous committed output
	logic signed [P_W-1:0]   product_q;   // mult stage register
	logic signed [P_W-1:0]   sum_q;       // acc stage register
	logic signed [P_W-1:0]   max_ext;     // bounds at sum width
	logic signed [P_W-1:0]   min_ext;
	logic signed [P_W-1:0]   hi_lim;      // after upper bound
	logic signed [P_W-1:0]   lo_lim;      // after lower bound

	//////////////////////////////
	// width conversion
	//////////////////////////////

	generate
		if (W_OUT < W_IN) begin : g_trunc
			assign sample_cnv = sample[W_IN-1 -: W_OUT];  // keep upper bits
		end else begin : g_sext
			assign sample_cnv = sample;  // signed, so sign-extended
		end
	endgenerate

	//////////////////////////////
	// clamp logic
	//////////////////////////////

	assign max_ext = act_max;  // sign-extend to sum width
	assign min_ext = act_min;

	// upper bound first, lower bound last so min wins on crossed bounds
	assign hi_lim = (sum_q > max_ext) ? max_ext : sum_q;
	assign lo_lim = (hi_lim < min_ext) ? min_ext : hi_lim;

	//////////////////////////////
	// stage registers
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (capture) begin
			sample_q <= sample_cnv;
		end
		case (stage)
			stg_mult:  product_q <= sample_q * act_gain;  // full precision
			stg_acc:   sum_q     <= product_q + prev_out; // prev sign-extended
			stg_clamp: result    <= lock_en ? lo_lim[W_OUT-1:0] : act_init;
			default:   ;                                  // stg_none holds
		endcase
	end

	//////////////////////////////
	// previous output register
	//////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			prev_out <= '0;
		end else if (reload) begin
			prev_out <= act_init;  // restart from new init
		end else if (commit) begin
			prev_out <= result;    // accumulate from last output
		end
	end

endmodule

// ==== src/opp_control.sv ====
`timescale 1ns/1ns
`include "opp_settings.svh"

module opp_control (
	input  logic                clk_in,        // system clock
	input  logic                reset_in,      // async reset
	input  logic                sample_valid,  // one-cycle sample strobe
	input  logic                dac_ack,       // queue acknowledge
	output logic                sample_ready,  // high only when idle
	output logic                capture,       // datapath latches sample
	output opp_pkg::opp_stage_t stage,         // stage opcode to datapath
	output logic                commit,        // latch previous output
	output logic                dac_req        // queue request
);
	import opp_pkg::*;

	localparam int LAT   = `OPP_COMP_LATENCY;
	localparam int CNT_W = (LAT > 1) ? $clog2(LAT) : 1;

	opp_state_t       cur_state;   // current state
	opp_state_t       next_state;  // next state
	logic [CNT_W-1:0] counter;     // intrastate counter
	logic             ack_seen;    // send substate, ack arrived

	//////////////////////////////
	// handshake to datapath
	//////////////////////////////

	assign sample_ready = (cur_state == st_idle);
	assign capture      = sample_ready & sample_valid;  // strobe ignored otherwise
	assign commit       = (cur_state == st_done);

	// one opcode per compute cycle
	always_comb begin
		stage = stg_none;
		if (cur_state == st_compute) begin
			if (counter == CNT_W'(0)) begin
				stage = stg_mult;
			end else if (counter == CNT_W'(1)) begin
				stage = stg_acc;
			end else if (counter == CNT_W'(2)) begin
				stage = stg_clamp;
			end
		end
	end

	//////////////////////////////
	// state machine
	//////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			cur_state <= st_idle;
		end else begin
			cur_state <= next_state;
		end
	end

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			counter <= '0;
		end else if (cur_state != next_state) begin
			counter <= '0;               // restart on state change
		end else if (cur_state == st_compute) begin
			counter <= counter + 1'b1;   // one step per stage
		end
	end

	always_comb begin
		next_state = cur_state;  // stay by default
		case (cur_state)
			st_idle: begin
				if (sample_valid) begin
					next_state = st_compute;
				end
			end
			st_compute: begin
				if (counter == CNT_W'(LAT - 1)) begin
					next_state = st_send;
				end
			end
			st_send: begin
				if (ack_seen && !dac_ack) begin
					next_state = st_done;  // ack fell with req low
				end
			end
			default: begin
				next_state = st_idle;  // st_done lasts one cycle
			end
		endcase
	end

	//////////////////////////////
	// four-phase dac handshake
	//////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			dac_req  <= 1'b0;
			ack_seen <= 1'b0;
		end else if (cur_state == st_send) begin
			if (!ack_seen && !dac_req && !dac_ack) begin
				dac_req <= 1'b1;   // raise once ack is low
			end else if (dac_req && dac_ack) begin
				dac_req  <= 1'b0;  // ack seen, drop req
				ack_seen <= 1'b1;
			end else if (ack_seen && !dac_ack) begin
				ack_seen <= 1'b0;  // transfer complete
			end
		end
	end

endmodule

// ==== src/opp_top.sv ====
`timescale 1ns/1ns
`include "opp_settings.svh"

module opp_top (
	input  logic                         clk_in,        // system clock
	input  logic                         reset_in,      // async reset

	// upstream error samples
	input  logic signed [`OPP_W_IN-1:0]  sample,        // error sample
	input  logic                         sample_valid,  // one-cycle strobe
	output logic                         sample_ready,  // accepting samples

	// front panel
	input  logic signed [`OPP_W_OUT-1:0] out_max,       // upper bound
	input  logic signed [`OPP_W_OUT-1:0] out_min,       // lower bound
	input  logic signed [`OPP_W_OUT-1:0] out_init,      // initial output
	input  logic signed [7:0]            gain,          // signed gain
	input  logic                         lock_en,       // lock enable
	input  logic                         update_en,     // arms update
	input  logic                         update,        // update pulse

	// dac command queue
	output logic signed [`OPP_W_OUT-1:0] dac_data,      // output word
	output logic                         dac_req,       // four-phase request
	input  logic                         dac_ack        // four-phase acknowledge
);
	import opp_pkg::*;

	logic signed [`OPP_W_OUT-1:0] act_max;   // active settings
	logic signed [`OPP_W_OUT-1:0] act_min;
	logic signed [`OPP_W_OUT-1:0] act_init;
	logic signed [7:0]            act_gain;
	logic                         reload;    // bank to datapath
	logic                         capture;   // control to datapath
	logic                         commit;
	opp_stage_t                   stage;

	//////////////////////////////
	// parameter bank
	//////////////////////////////

	opp_param_bank opp_param_bank_inst (
		.clk_in          (clk_in),
		.reset_in        (reset_in),
		.update          (update),
		.update_en       (update_en),
		.out_max_in_val  (out_max),
		.out_min_in_val  (out_min),
		.out_init_in_val (out_init),
		.gain_in_val     (gain),
		.act_max         (act_max),
		.act_min         (act_min),
		.act_init        (act_init),
		.act_gain        (act_gain),
		.reload          (reload)
	);

	//////////////////////////////
	// control and datapath
	//////////////////////////////

	opp_control opp_control_inst (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.sample_valid (sample_valid),
		.dac_ack      (dac_ack),
		.sample_ready (sample_ready),
		.capture      (capture),
		.stage        (stage),
		.commit       (commit),
		.dac_req      (dac_req)
	);

	opp_datapath opp_datapath_inst (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.sample   (sample),
		.capture  (capture),
		.stage    (stage),
		.commit   (commit),
		.reload   (reload),
		.act_max  (act_max),
		.act_min  (act_min),
		.act_init (act_init),
		.act_gain (act_gain),
		.lock_en  (lock_en),
		.result   (dac_data)  // held while req is high
	);

endmodule

// ==== bench/opp_asserts.sv ====
`timescale 1ns/1ns

module opp_asserts (
	input logic                clk_in,     // system clock
	input logic                reset_in,   // async reset
	input logic                dac_req,    // queue request
	input logic                dac_ack,    // queue acknowledge
	input opp_pkg::opp_state_t cur_state   // control FSM state
);
	import opp_pkg::*;

	int fail_count = 0;  // polled by the testbench

	//////////////////////////////
	// four-phase handshake
	//////////////////////////////

	req_waits_ack_low: assert property (@(posedge clk_in) disable iff (reset_in)
		(!dac_req && dac_ack) |=> !dac_req)  // old ack still high
	else begin
		fail_count++;
		$error("dac_req rose while dac_ack was high");
	end

	req_holds: assert property (@(posedge clk_in) disable iff (reset_in)
		(dac_req && !dac_ack) |=> dac_req)
	else begin
		fail_count++;
		$error("dac_req dropped before dac_ack");
	end

	req_in_send: assert property (@(posedge clk_in) disable iff (reset_in)
		dac_req |-> (cur_state == st_send))
	else begin
		fail_count++;
		$error("dac_req high outside st_send");
	end

	//////////////////////////////
	// state legality
	//////////////////////////////

	state_known: assert property (@(posedge clk_in) disable iff (reset_in)
		!$isunknown(cur_state))
	else begin
		fail_count++;
		$error("control state unknown");
	end

	state_step: assert property (@(posedge clk_in) disable iff (reset_in)
		((cur_state == st_idle)    |=> (cur_state inside {st_idle, st_compute})) and
		((cur_state == st_compute) |=> (cur_state inside {st_compute, st_send})) and
		((cur_state == st_send)    |=> (cur_state inside {st_send, st_done})) and
		((cur_state == st_done)    |=> (cur_state == st_idle)))  // done is one cycle
	else begin
		fail_count++;
		$error("illegal control state transition");
	end

endmodule

bind opp_control opp_asserts opp_asserts_inst (
	.clk_in    (clk_in),
	.reset_in  (reset_in),
	.dac_req   (dac_req),
	.dac_ack   (dac_ack),
	.cur_state (cur_state)
);

// ==== bench/opp_tb.sv ====
`timescale 1ns/1ns
`include "opp_settings.svh"

module opp_tb;
	import opp_pkg::*;

	localparam int W_IN           = `OPP_W_IN;
	localparam int W_OUT          = `OPP_W_OUT;
	localparam int SHIFT          = (W_IN > W_OUT) ? W_IN - W_OUT : 0;  // dropped low bits
	localparam int N_SAMPLES      = 400;  // upper bound on samples issued
	localparam int CYC_PER_SAMPLE = 30;
	localparam int TIMEOUT_CYCLES = N_SAMPLES * CYC_PER_SAMPLE;

	localparam logic signed [W_OUT-1:0] OUT_HI = {1'b0, {(W_OUT-1){1'b1}}};  // widest window
	localparam logic signed [W_OUT-1:0] OUT_LO = {1'b1, {(W_OUT-1){1'b0}}};

	logic                    clk_in;
	logic                    reset_in;
	logic signed [W_IN-1:0]  sample;
	logic                    sample_valid;
	logic                    sample_ready;
	logic signed [W_OUT-1:0] out_max;
	logic signed [W_OUT-1:0] out_min;
	logic signed [W_OUT-1:0] out_init;
	logic signed [7:0]       gain;
	logic                    lock_en;
	logic                    update_en;
	logic                    update;
	logic signed [W_OUT-1:0] dac_data;
	logic                    dac_req;
	logic                    dac_ack;

	// reference model state
	logic signed [W_OUT-1:0] m_max;
	logic signed [W_OUT-1:0] m_min;
	logic signed [W_OUT-1:0] m_init;
	logic signed [W_OUT-1:0] m_prev;      // model's previous output
	logic signed [7:0]       m_gain;
	logic signed [W_OUT-1:0] exp_q[$];    // results awaiting transfer

	logic [31:0]             lfsr_state = 32'hf393_59b4;
	int                      ack_bits   = 3;  // responder delay width
	int                      cycles     = 0;
	int                      sent       = 0;
	int                      received   = 0;
	logic                    req_prev   = 1'b0;
	logic signed [W_OUT-1:0] held_data;   // word seen at req rise

	opp_top opp_top_inst (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.sample       (sample),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.out_max      (out_max),
		.out_min      (out_min),
		.out_init     (out_init),
		.gain         (gain),
		.lock_en      (lock_en),
		.update_en    (update_en),
		.update       (update),
		.dac_data     (dac_data),
		.dac_req      (dac_req),
		.dac_ack      (dac_ack)
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on first failure");
	endtask

	// galois form, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);  // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic signed [31:0] rand_signed(input int n);
		logic [31:0] v;
		v = rand_bits(n);
		return $signed(v << (32 - n)) >>> (32 - n);  // sign-extend n bits
	endfunction

	// expected output word from the loop rule
	function automatic logic signed [W_OUT-1:0] ref_output(
		input logic signed [W_IN-1:0]  smp,
		input logic signed [7:0]       g,
		input logic signed [W_OUT-1:0] prev,
		input logic signed [W_OUT-1:0] mx,
		input logic signed [W_OUT-1:0] mn,
		input logic signed [W_OUT-1:0] init,
		input logic                    lock
	);
		longint conv;
		longint sum;
		if (!lock) begin
			return init;  // open loop holds init
		end
		conv = longint'(smp) >>> SHIFT;  // floor of smp / 2**SHIFT
		sum  = conv * longint'(g) + longint'(prev);
		if (sum > longint'(mx)) sum = longint'(mx);
		if (sum < longint'(mn)) sum = longint'(mn);  // min wins last
		return sum[W_OUT-1:0];
	endfunction

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////

	task automatic wait_idle();
		@(negedge clk_in);
		while (!sample_ready) @(negedge clk_in);
	endtask

	task automatic send_sample(input logic signed [W_IN-1:0] smp);
		logic signed [W_OUT-1:0] e;
		wait_idle();
		sample       = smp;
		sample_valid = 1'b1;  // accepted at the next rising edge
		e = ref_output(smp, m_gain, m_prev, m_max, m_min, m_init, lock_en);
		exp_q.push_back(e);
		m_prev = e;
		sent++;
		@(negedge clk_in);
		sample_valid = 1'b0;
	endtask

	task automatic set_params(
		input logic signed [W_OUT-1:0] mx,
		input logic signed [W_OUT-1:0] mn,
		input logic signed [W_OUT-1:0] init,
		input logic signed [7:0]       g,
		input logic                    en
	);
		wait_idle();
		out_max   = mx;
		out_min   = mn;
		out_init  = init;
		gain      = g;
		update    = 1'b1;
		update_en = en;
		if (en) begin
			m_max  = mx;
			m_min  = mn;
			m_init = init;
			m_gain = g;
			m_prev = init;  // gated update reloads the accumulator
		end
		@(negedge clk_in);
		update    = 1'b0;
		update_en = 1'b0;
		repeat (2) @(negedge clk_in);  // let reload land
	endtask

	task automatic set_lock(input logic en);
		wait_idle();
		lock_en = en;
	endtask

	task automatic check_params();
		assert (opp_top_inst.opp_param_bank_inst.act_max  == m_max &&
			opp_top_inst.opp_param_bank_inst.act_min  == m_min &&
			opp_top_inst.opp_param_bank_inst.act_init == m_init &&
			opp_top_inst.opp_param_bank_inst.act_gain == m_gain)
		else fail_run($sformatf("error at %0t ns: active parameters changed without update_en",
			$time));
	endtask

	//////////////////////////////
	// clock, timeout, responder
	//////////////////////////////

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;  // 10 ns period
	end

	always @(posedge clk_in) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	// dac queue model, random ack delays both ways
	initial begin : ack_responder
		logic [31:0] d;
		dac_ack = 1'b0;
		forever begin
			@(negedge clk_in);
			if (dac_req && !dac_ack) begin
				d = rand_bits(ack_bits);
				repeat (d) @(negedge clk_in);
				dac_ack = 1'b1;
				while (dac_req) @(negedge clk_in);  // wait for req to drop
				d = rand_bits(ack_bits);
				repeat (d) @(negedge clk_in);
				dac_ack = 1'b0;
			end
		end
	end

	//////////////////////////////
	// result comparison
	//////////////////////////////

	// dut outputs settle after the rising edge, so look at the falling one
	always @(negedge clk_in) begin : compare_results
		logic signed [W_OUT-1:0] exp_val;
		if (!reset_in) begin
			if (dac_req && !req_prev) begin
				assert (exp_q.size() > 0)
				else fail_run("a DAC transfer started with no sample pending");
				exp_val = exp_q.pop_front();
				received++;
				assert (dac_data === exp_val)
				else fail_run($sformatf("error at %0t ns: dac_data %0d, expected %0d (result %0d)",
					$time, dac_data, exp_val, received));
				held_data = dac_data;
			end else if (dac_req) begin
				assert (dac_data === held_data)  // hold under back-pressure
				else fail_run($sformatf("error at %0t ns: dac_data moved from %0d to %0d under req",
					$time, held_data, dac_data));
			end
			if (dac_req || dac_ack) begin  // transfer open until ack falls
				assert (!sample_ready)
				else fail_run("sample_ready went high during a DAC transfer");
			end
			req_prev = dac_req;
		end
	end

	always @(negedge clk_in) begin
		assert (opp_top_inst.opp_control_inst.opp_asserts_inst.fail_count == 0)
		else fail_run("a bound handshake or state assertion failed");
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin : stimulus
		logic signed [7:0]      g;
		logic signed [W_IN-1:0] smp;
		reset_in     = 1'b1;
		sample       = '0;
		sample_valid = 1'b0;
		out_max      = '0;
		out_min      = '0;
		out_init     = '0;
		gain         = '0;
		lock_en      = 1'b1;
		update_en    = 1'b0;
		update       = 1'b0;
		m_max        = '0;  // matches the reset state of the bank
		m_min        = '0;
		m_init       = '0;
		m_gain       = '0;
		m_prev       = '0;
		repeat (10) @(posedge clk_in);
		@(negedge clk_in);
		reset_in = 1'b0;
		assert (sample_ready && !dac_req)
		else fail_run("DUT not idle after reset");

		// accumulation, new gain and init every block
		for (int blk = 0; blk < 10; blk++) begin
			set_params(OUT_HI, OUT_LO, W_OUT'(rand_signed(12)), 8'(rand_signed(4)), 1'b1);
			for (int i = 0; i < 12; i++) send_sample(W_IN'(rand_signed(12)));
		end

		// clamping, large gains against narrow windows
		g = 8'(64 + rand_bits(6));
		set_params(16'sd300, -16'sd300, 16'sd0, g, 1'b1);
		for (int i = 0; i < 20; i++) send_sample(W_IN'(rand_signed(W_IN)));
		g = -8'(64 + rand_bits(6));
		set_params(16'sd2000, 16'sd1500, 16'sd1700, g, 1'b1);
		for (int i = 0; i < 20; i++) send_sample(W_IN'(rand_signed(W_IN)));
		set_params(-16'sd100, 16'sd100, 16'sd0, 8'sd120, 1'b1);  // crossed bounds
		for (int i = 0; i < 20; i++) send_sample(W_IN'(rand_signed(W_IN)));

		// lock off holds init, then resumes from it
		set_params(OUT_HI, OUT_LO, 16'sd1234, 8'sd3, 1'b1);
		for (int i = 0; i < 10; i++) send_sample(W_IN'(rand_signed(14)));
		set_lock(1'b0);
		for (int i = 0; i < 15; i++) send_sample(W_IN'(rand_signed(14)));
		set_lock(1'b1);
		for (int i = 0; i < 15; i++) send_sample(W_IN'(rand_signed(14)));

		// update gating
		set_params(OUT_HI, OUT_LO, -16'sd777, 8'sd5, 1'b1);
		for (int i = 0; i < 10; i++) send_sample(W_IN'(rand_signed(12)));
		set_params(16'sd10, -16'sd10, 16'sd99, -8'sd50, 1'b0);  // update_en low
		check_params();
		for (int i = 0; i < 10; i++) send_sample(W_IN'(rand_signed(12)));
		set_params(OUT_HI, OUT_LO, 16'sd4321, -8'sd2, 1'b1);
		for (int i = 0; i < 10; i++) send_sample(W_IN'(rand_signed(12)));

		// back-pressure, ack delays up to 31 cycles
		set_params(OUT_HI, OUT_LO, 16'sd0, 8'sd7, 1'b1);
		ack_bits = 5;
		for (int i = 0; i < 20; i++) send_sample(W_IN'(rand_signed(12)));
		ack_bits = 3;

		// width conversion, low bits always nonzero
		set_params(OUT_HI, OUT_LO, 16'sd0, 8'(rand_signed(4) | 1), 1'b1);  // odd gain, never 0
		for (int i = 0; i < 40; i++) begin
			smp    = W_IN'(rand_signed(12));  // small enough to stay off the window
			smp[0] = 1'b1;
			send_sample(smp);
		end

		wait_idle();
		assert (exp_q.size() == 0 && received == sent)
		else fail_run($sformatf("error at %0t ns: %0d samples sent, %0d results received",
			$time, sent, received));
		if (opp_top_inst.opp_control_inst.opp_asserts_inst.fail_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "bound assertions reported failures");
		end
	end

endmodule

// ==== sim.f ====
+incdir+include
src/opp_pkg.sv
src/opp_param_bank.sv
src/opp_datapath.sv
src/opp_control.sv
src/opp_top.sv
bench/opp_asserts.sv
bench/opp_tb.sv

// ==== Bender.yml ====
package:
  name: opp

export_include_dirs:
  - include

sources:
  # design
  - files:
      - src/opp_pkg.sv
      - src/opp_param_bank.sv
      - src/opp_datapath.sv
      - src/opp_control.sv
      - src/opp_top.sv

  # testbench
  - target: simulation
    files:
      - bench/opp_asserts.sv
      - bench/opp_tb.sv
